// File: verilog/tile_map_settings.svh
`ifndef TILE_MAP_SETTINGS_SVH
`define TILE_MAP_SETTINGS_SVH

// ---------------------------------------------------------------------------
// map geometry
// ---------------------------------------------------------------------------

// the map is stored row after row, so an entry sits at row * columns + column.
`define MAP_NUM_ROW 11
`define MAP_NUM_COL 19
`define MAP_DEPTH (`MAP_NUM_ROW * `MAP_NUM_COL)
`define MAP_ADDR_WIDTH 8

// ---------------------------------------------------------------------------
// tiles and sprites
// ---------------------------------------------------------------------------

`define TILE_CODE_WIDTH 2

// tiles are 64 pixels square.
`define TILE_SHIFT 6
`define COORD_WIDTH 11

`define SPRITE_W 32
`define SPRITE_H 48

// a sprite may not overlap a tile with this code.
`define TILE_WALL 2'd1

`endif

// File: verilog/tile_map_pkg.sv
`default_nettype none

`include "tile_map_settings.svh"

package tile_map_pkg;

    typedef logic [`MAP_ADDR_WIDTH-1:0] map_addr_t;
    typedef logic [`TILE_CODE_WIDTH-1:0] tile_code_t;
    typedef logic [`COORD_WIDTH-1:0] pixel_coord_t;

    typedef enum logic { ARB_IDLE, ARB_BUSY } arb_state_t;
    typedef enum logic [1:0] { FETCH_IDLE, FETCH_REQ, FETCH_DATA } fetch_state_t;
    typedef enum logic [1:0] { CHECK_IDLE, CHECK_REQ, CHECK_DATA } check_state_t;

    // map entry under a pixel position.
    // both readers address the map through this one mapping.
    function automatic map_addr_t map_index(input pixel_coord_t x, input pixel_coord_t y);
        map_addr_t row;
        map_addr_t col;
        row = map_addr_t'(y >> `TILE_SHIFT);
        col = map_addr_t'(x >> `TILE_SHIFT);
        return map_addr_t'(row * map_addr_t'(`MAP_NUM_COL) + col);
    endfunction

endpackage

`default_nettype wire

// File: verilog/mem_read_if.sv
`timescale 1ns/1ns
`default_nettype none

// one reader's link to the read arbiter.
// the reader holds req with a stable addr until it has taken the data.
interface mem_read_if;
    import tile_map_pkg::*;

    logic req;
    map_addr_t addr;
    logic granted;
    tile_code_t data;

    modport reader (
        output req,
        output addr,
        input  granted,
        input  data
    );

    modport arbiter (
        input  req,
        input  addr,
        output granted,
        output data
    );

endinterface

`default_nettype wire

// File: verilog/mem_read_controller.sv
`timescale 1ns/1ns
`default_nettype none

module mem_read_controller (
    input  wire logic                  clk,
    input  wire logic                  rst,
    mem_read_if.arbiter                rd0,
    mem_read_if.arbiter                rd1,
    output tile_map_pkg::map_addr_t    mem_addr,
    input  wire tile_map_pkg::tile_code_t mem_data
);
    import tile_map_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    logic [1:0] grant;
    logic read_done;

    // ------------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ARB_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ARB_IDLE: if (rd0.req || rd1.req) state_next = ARB_BUSY;
            ARB_BUSY: if (read_done) state_next = ARB_IDLE;
            default: state_next = ARB_IDLE;
        endcase
    end

    // the grant is only picked in IDLE, so a waiting reader cannot take over
    // a read in progress. reader 1 wins a tie.
    always_ff @(posedge clk)
    begin
        if (rst)
            grant <= 2'b00;
        else
        begin
            case (state)
                ARB_IDLE:
                begin
                    if (rd1.req)
                        grant <= 2'b10;
                    else if (rd0.req)
                        grant <= 2'b01;
                    else
                        grant <= 2'b00;
                end
                ARB_BUSY: if (read_done) grant <= 2'b00;
                default: grant <= 2'b00;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // address mux and data fan-out
    // ------------------------------------------------------------------------

    always_comb
    begin
        case (grant)
            2'b10: mem_addr = rd1.addr;
            2'b01: mem_addr = rd0.addr;
            default: mem_addr = '0;
        endcase
    end

    // the holder dropping its request marks the end of its read.
    always_comb
    begin
        case (grant)
            2'b10: read_done = ~rd1.req;
            2'b01: read_done = ~rd0.req;
            default: read_done = 1'b0;
        endcase
    end

    assign rd0.granted = grant[0];
    assign rd1.granted = grant[1];
    assign rd0.data = mem_data;
    assign rd1.data = mem_data;

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(rd0.granted && rd1.granted));

endmodule

`default_nettype wire

// File: verilog/tile_map_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "tile_map_settings.svh"

module tile_map_mem (
    input  wire logic                     clk,
    input  wire logic                     wr_en,
    input  wire tile_map_pkg::map_addr_t  wr_addr,
    input  wire tile_map_pkg::tile_code_t wr_data,
    input  wire tile_map_pkg::map_addr_t  rd_addr,
    output tile_map_pkg::tile_code_t      rd_data
);
    import tile_map_pkg::*;

    tile_code_t mem [0:`MAP_DEPTH-1];

    // the read samples the array before this edge's write lands, so a read
    // of the address being written returns the old code.
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];
    end

    a_wr_in_map: assert property (@(posedge clk)
        wr_en |-> (wr_addr < `MAP_DEPTH));

    a_rd_in_map: assert property (@(posedge clk)
        rd_addr < `MAP_DEPTH);

endmodule

`default_nettype wire

// File: verilog/tile_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "tile_map_settings.svh"

module tile_fetch (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       start,
    input  wire tile_map_pkg::pixel_coord_t pix_x,
    input  wire tile_map_pkg::pixel_coord_t pix_y,
    mem_read_if.reader                      rd,
    output tile_map_pkg::tile_code_t        tile,
    output logic                            valid
);
    import tile_map_pkg::*;

    fetch_state_t state;
    map_addr_t addr_q;

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------

    // a start pulse is only taken in IDLE.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= FETCH_IDLE;
            valid <= 1'b0;
        end
        else
        begin
            valid <= 1'b0;
            case (state)
                FETCH_IDLE: if (start) state <= FETCH_REQ;
                FETCH_REQ: if (rd.granted) state <= FETCH_DATA;
                FETCH_DATA:
                begin
                    state <= FETCH_IDLE;
                    valid <= 1'b1;
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // address and result
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (state == FETCH_IDLE && start)
            addr_q <= map_index(pix_x, pix_y);
        // memory data is valid the cycle after the grant was seen.
        if (state == FETCH_DATA)
            tile <= rd.data;
    end

    assign rd.req = (state == FETCH_REQ);
    assign rd.addr = addr_q;

    a_addr_in_map: assert property (@(posedge clk) disable iff (rst)
        rd.req |-> (rd.addr < `MAP_DEPTH));

endmodule

`default_nettype wire

// File: verilog/collision_check.sv
`timescale 1ns/1ns
`default_nettype none

`include "tile_map_settings.svh"

module collision_check (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       start,
    input  wire tile_map_pkg::pixel_coord_t sprite_x,
    input  wire tile_map_pkg::pixel_coord_t sprite_y,
    mem_read_if.reader                      rd,
    output logic                            blocked,
    output logic                            done
);
    import tile_map_pkg::*;

    check_state_t state;
    logic [1:0] corner;
    pixel_coord_t x_q;
    pixel_coord_t y_q;
    pixel_coord_t corner_x;
    pixel_coord_t corner_y;
    logic hit;
    logic hit_next;

    // ------------------------------------------------------------------------
    // corner walk
    // ------------------------------------------------------------------------

    // bit 0 of the counter picks the right edge, bit 1 the bottom edge.
    assign corner_x = corner[0] ? x_q + pixel_coord_t'(`SPRITE_W - 1) : x_q;
    assign corner_y = corner[1] ? y_q + pixel_coord_t'(`SPRITE_H - 1) : y_q;

    assign hit_next = hit | (rd.data == `TILE_WALL);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= CHECK_IDLE;
            corner <= 2'd0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                CHECK_IDLE:
                begin
                    if (start)
                    begin
                        state <= CHECK_REQ;
                        corner <= 2'd0;
                    end
                end
                CHECK_REQ: if (rd.granted) state <= CHECK_DATA;
                CHECK_DATA:
                begin
                    // each corner needs its own grant, so request again.
                    if (corner == 2'd3)
                    begin
                        state <= CHECK_IDLE;
                        done <= 1'b1;
                    end
                    else
                    begin
                        state <= CHECK_REQ;
                        corner <= corner + 2'd1;
                    end
                end
                default: state <= CHECK_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // position and hit flag
    // ------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (state == CHECK_IDLE && start)
        begin
            x_q <= sprite_x;
            y_q <= sprite_y;
            hit <= 1'b0;
        end
        else if (state == CHECK_DATA)
        begin
            hit <= hit_next;
            if (corner == 2'd3)
                blocked <= hit_next;
        end
    end

    assign rd.req = (state == CHECK_REQ);
    assign rd.addr = map_index(corner_x, corner_y);

    // every corner the walk reads must lie inside the map.
    a_addr_in_map: assert property (@(posedge clk) disable iff (rst)
        rd.req |-> (rd.addr < `MAP_DEPTH));

endmodule

`default_nettype wire

// File: verilog/tile_map_top.sv
`timescale 1ns/1ns
`default_nettype none

module tile_map_top (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       map_wr_en,
    input  wire tile_map_pkg::map_addr_t    map_wr_addr,
    input  wire tile_map_pkg::tile_code_t   map_wr_data,
    input  wire logic                       fetch_start,
    input  wire tile_map_pkg::pixel_coord_t fetch_x,
    input  wire tile_map_pkg::pixel_coord_t fetch_y,
    input  wire logic                       sprite_start,
    input  wire tile_map_pkg::pixel_coord_t sprite_x,
    input  wire tile_map_pkg::pixel_coord_t sprite_y,
    output tile_map_pkg::tile_code_t        fetch_tile,
    output logic                            fetch_valid,
    output logic                            sprite_blocked,
    output logic                            sprite_done
);
    import tile_map_pkg::*;

    map_addr_t mem_addr;
    tile_code_t mem_data;

    mem_read_if fetch_rd ();
    mem_read_if check_rd ();

    // collision reads sit on the high-priority port.
    mem_read_controller u_arb (
        .clk      (clk),
        .rst      (rst),
        .rd0      (fetch_rd.arbiter),
        .rd1      (check_rd.arbiter),
        .mem_addr (mem_addr),
        .mem_data (mem_data)
    );

    tile_map_mem u_mem (
        .clk     (clk),
        .wr_en   (map_wr_en),
        .wr_addr (map_wr_addr),
        .wr_data (map_wr_data),
        .rd_addr (mem_addr),
        .rd_data (mem_data)
    );

    tile_fetch u_fetch (
        .clk   (clk),
        .rst   (rst),
        .start (fetch_start),
        .pix_x (fetch_x),
        .pix_y (fetch_y),
        .rd    (fetch_rd.reader),
        .tile  (fetch_tile),
        .valid (fetch_valid)
    );

    collision_check u_check (
        .clk      (clk),
        .rst      (rst),
        .start    (sprite_start),
        .sprite_x (sprite_x),
        .sprite_y (sprite_y),
        .rd       (check_rd.reader),
        .blocked  (sprite_blocked),
        .done     (sprite_done)
    );

endmodule

`default_nettype wire

// File: verification/tile_map_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "tile_map_settings.svh"

module tile_map_tb;
    import tile_map_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAP_W_PIX = `MAP_NUM_COL << `TILE_SHIFT;
    localparam int MAP_H_PIX = `MAP_NUM_ROW << `TILE_SHIFT;
    localparam int PULSE_BOUND = 64;
    // random fetches, random sprites, contention runs and directed cases.
    localparam int NUM_OPS = 120;
    localparam int OP_CYCLES = 40;
    localparam int WATCHDOG_NS = (NUM_OPS * OP_CYCLES + `MAP_DEPTH + 100) * CLK_PERIOD;

    logic clk;
    logic rst;
    logic map_wr_en;
    map_addr_t map_wr_addr;
    tile_code_t map_wr_data;
    logic fetch_start;
    pixel_coord_t fetch_x;
    pixel_coord_t fetch_y;
    logic sprite_start;
    pixel_coord_t sprite_x;
    pixel_coord_t sprite_y;
    tile_code_t fetch_tile;
    logic fetch_valid;
    logic sprite_blocked;
    logic sprite_done;

    tile_code_t model [0:`MAP_DEPTH-1];
    int seed = 4117;
    int value_errors = 0;
    int timeout_errors = 0;

    tile_map_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .map_wr_en      (map_wr_en),
        .map_wr_addr    (map_wr_addr),
        .map_wr_data    (map_wr_data),
        .fetch_start    (fetch_start),
        .fetch_x        (fetch_x),
        .fetch_y        (fetch_y),
        .sprite_start   (sprite_start),
        .sprite_x       (sprite_x),
        .sprite_y       (sprite_y),
        .fetch_tile     (fetch_tile),
        .fetch_valid    (fetch_valid),
        .sprite_blocked (sprite_blocked),
        .sprite_done    (sprite_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    // tiles are 64 pixels square and the map is stored row by row.
    function automatic tile_code_t model_tile(input int x, input int y);
        return model[(y / 64) * `MAP_NUM_COL + x / 64];
    endfunction

    function automatic logic model_blocked(input int x, input int y);
        return (model_tile(x, y) == `TILE_WALL)
            || (model_tile(x + `SPRITE_W - 1, y) == `TILE_WALL)
            || (model_tile(x, y + `SPRITE_H - 1) == `TILE_WALL)
            || (model_tile(x + `SPRITE_W - 1, y + `SPRITE_H - 1) == `TILE_WALL);
    endfunction

    task automatic check_tile(input tile_code_t got, input tile_code_t exp, input string msg);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail %0t: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_blocked(input logic got, input logic exp, input string msg);
        if (got !== exp)
        begin
            value_errors++;
            $display("Fail %0t: %s, got %0b expected %0b", $time, msg, got, exp);
        end
    endtask

    task automatic write_tile(input int row, input int col, input tile_code_t code);
        @(negedge clk);
        map_wr_en = 1'b1;
        map_wr_addr = map_addr_t'(row * `MAP_NUM_COL + col);
        map_wr_data = code;
        model[row * `MAP_NUM_COL + col] = code;
        @(negedge clk);
        map_wr_en = 1'b0;
    endtask

    task automatic load_map();
        for (int a = 0; a < `MAP_DEPTH; a++)
            write_tile(a / `MAP_NUM_COL, a % `MAP_NUM_COL, tile_code_t'($random(seed)));
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    // starts a fetch, a sprite check or both in one cycle and waits for the
    // done pulses, checking each result as it shows up.
    task automatic start_and_check(input logic do_fetch, input int fx, input int fy,
                                   input logic do_sprite, input int sx, input int sy);
        tile_code_t exp_tile;
        logic exp_blocked;
        logic got_f;
        logic got_s;
        int cycles;
        exp_tile = model_tile(fx, fy);
        exp_blocked = model_blocked(sx, sy);
        got_f = !do_fetch;
        got_s = !do_sprite;
        cycles = 0;
        @(negedge clk);
        fetch_start = do_fetch;
        fetch_x = pixel_coord_t'(fx);
        fetch_y = pixel_coord_t'(fy);
        sprite_start = do_sprite;
        sprite_x = pixel_coord_t'(sx);
        sprite_y = pixel_coord_t'(sy);
        @(negedge clk);
        fetch_start = 1'b0;
        sprite_start = 1'b0;
        while (!(got_f && got_s) && cycles < PULSE_BOUND)
        begin
            if (!got_f && fetch_valid)
            begin
                got_f = 1'b1;
                check_tile(fetch_tile, exp_tile, $sformatf("tile at pixel (%0d, %0d)", fx, fy));
            end
            if (!got_s && sprite_done)
            begin
                got_s = 1'b1;
                check_blocked(sprite_blocked, exp_blocked,
                              $sformatf("blocked for sprite at (%0d, %0d)", sx, sy));
            end
            if (!(got_f && got_s))
            begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!got_f)
        begin
            timeout_errors++;
            $display("fetch_valid never pulsed for pixel (%0d, %0d)", fx, fy);
        end
        if (!got_s)
        begin
            timeout_errors++;
            $display("sprite_done never pulsed for sprite at (%0d, %0d)", sx, sy);
        end
    endtask

    function automatic int rand_below(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------

    task automatic test_idle_after_reset();
        repeat (8)
        begin
            @(negedge clk);
            if (fetch_valid || sprite_done)
            begin
                value_errors++;
                $display("Fail %0t: done pulse seen before any start", $time);
            end
        end
    endtask

    task automatic test_random_fetch();
        repeat (40)
            start_and_check(1'b1, rand_below(MAP_W_PIX), rand_below(MAP_H_PIX), 1'b0, 0, 0);
    endtask

    task automatic test_random_sprite();
        repeat (40)
            start_and_check(1'b0, 0, 0, 1'b1, rand_below(MAP_W_PIX - `SPRITE_W + 1),
                            rand_below(MAP_H_PIX - `SPRITE_H + 1));
    endtask

    task automatic test_directed_sprite();
        // corners fall in columns 4 and 5 and rows 3 and 4.
        write_tile(3, 4, 2'd0);
        write_tile(3, 5, 2'd0);
        write_tile(4, 4, 2'd0);
        write_tile(4, 5, 2'd2);
        start_and_check(1'b0, 0, 0, 1'b1, 304, 232);
        write_tile(4, 5, `TILE_WALL);
        start_and_check(1'b0, 0, 0, 1'b1, 304, 232);
        // this sprite lies inside tile (3, 2).
        write_tile(3, 2, 2'd3);
        start_and_check(1'b0, 0, 0, 1'b1, 136, 200);
        write_tile(3, 2, `TILE_WALL);
        start_and_check(1'b0, 0, 0, 1'b1, 136, 200);
    endtask

    task automatic test_contention();
        repeat (20)
            start_and_check(1'b1, rand_below(MAP_W_PIX), rand_below(MAP_H_PIX),
                            1'b1, rand_below(MAP_W_PIX - `SPRITE_W + 1),
                            rand_below(MAP_H_PIX - `SPRITE_H + 1));
    endtask

    task automatic test_map_update();
        int x;
        int y;
        x = rand_below(MAP_W_PIX - `SPRITE_W + 1);
        y = rand_below(MAP_H_PIX - `SPRITE_H + 1);
        start_and_check(1'b1, x, y, 1'b1, x, y);
        write_tile(y / 64, x / 64, `TILE_WALL);
        start_and_check(1'b1, x, y, 1'b0, 0, 0);
        start_and_check(1'b0, 0, 0, 1'b1, x, y);
        write_tile(y / 64, x / 64, 2'd3);
        start_and_check(1'b1, x, y, 1'b1, x, y);
    endtask

    initial
    begin
        rst = 1'b1;
        map_wr_en = 1'b0;
        map_wr_addr = '0;
        map_wr_data = '0;
        fetch_start = 1'b0;
        fetch_x = '0;
        fetch_y = '0;
        sprite_start = 1'b0;
        sprite_x = '0;
        sprite_y = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_idle_after_reset();
        load_map();
        test_random_fetch();
        test_random_sprite();
        test_directed_sprite();
        test_contention();
        test_map_update();

        $display("errors: %0d wrong values, %0d missing pulses", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/tile_map_pkg.sv
verilog/mem_read_if.sv
verilog/mem_read_controller.sv
verilog/tile_map_mem.sv
verilog/tile_fetch.sv
verilog/collision_check.sv
verilog/tile_map_top.sv
verification/tile_map_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the tile map testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tile_map_tb -o tile_map_sim

./obj_dir/tile_map_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
